//--- bench/exe_props.sv
`include "exe_defines.svh"

module exe_props (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 wb_flush,
    input logic                 flush,
    input logic                 branch_valid,
    input logic                 res0_valid,
    input logic                 res1_valid,
    input logic [`EXE_XLEN-1:0] redirect_pc
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // a redirect comes from a resolved branch and lasts one cycle
    flush_has_branch: assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> branch_valid ##1 !flush)
        else begin
            fail_count++;
            $error("flush without branch_valid or longer than one cycle");
        end

    wb_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        wb_flush |=> !res0_valid && !res1_valid)
        else begin
            fail_count++;
            $error("result valid after wb_flush");
        end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !flush && !branch_valid && !res0_valid && !res1_valid)
        else begin
            fail_count++;
            $error("output active during reset");
        end

    redirect_known: assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> !$isunknown(redirect_pc))
        else begin
            fail_count++;
            $error("redirect_pc unknown under flush");
        end

endmodule

bind exe_top exe_props props0 (.*);

//--- bench/exe_tb.sv
`include "exe_defines.svh"

module exe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PHASES = 7;
    localparam int P_FWD      = 1;
    localparam int P_MUL      = 2;
    localparam int P_BR       = 3;
    localparam int P_FLUSH    = 4;
    localparam int P_WBF      = 5;
    localparam int P_IDLE     = 6;

    localparam int TOTAL_BUNDLES = 200 + 200 + 200 + 200 + 100 + 150 + 4;
    localparam int CYCLE_LIMIT   = TOTAL_BUNDLES + 100;

    logic                   clk;
    logic                   arst_n;
    logic                   wb_flush;
    logic                   lane0_valid;
    exe_pkg::exe_uop_t      lane0_uop;
    logic [`EXE_REG_AW-1:0] lane0_rd;
    logic [`EXE_REG_AW-1:0] lane0_rj;
    logic [`EXE_REG_AW-1:0] lane0_rk;
    logic [`EXE_XLEN-1:0]   lane0_imm;
    logic [`EXE_XLEN-1:0]   lane0_pc;
    logic [`EXE_XLEN-1:0]   lane0_pc_next;
    logic [`EXE_XLEN-1:0]   lane0_rj_data;
    logic [`EXE_XLEN-1:0]   lane0_rk_data;
    logic                   lane1_valid;
    exe_pkg::exe_uop_t      lane1_uop;
    logic [`EXE_REG_AW-1:0] lane1_rd;
    logic [`EXE_REG_AW-1:0] lane1_rj;
    logic [`EXE_REG_AW-1:0] lane1_rk;
    logic [`EXE_XLEN-1:0]   lane1_imm;
    logic [`EXE_XLEN-1:0]   lane1_rj_data;
    logic [`EXE_XLEN-1:0]   lane1_rk_data;
    logic                   res0_valid;
    logic [`EXE_REG_AW-1:0] res0_rd;
    logic [`EXE_XLEN-1:0]   res0_data;
    logic                   res1_valid;
    logic [`EXE_REG_AW-1:0] res1_rd;
    logic [`EXE_XLEN-1:0]   res1_data;
    logic                   flush;
    logic [`EXE_XLEN-1:0]   redirect_pc;
    logic                   branch_valid;
    logic                   branch_taken;
    logic [`EXE_XLEN-1:0]   branch_pc;

    // model state
    logic [31:0]          lfsr;
    logic [31:0]          pred_rf [32];
    logic [31:0]          comm_rf [32];
    exe_pkg::exe_result_t exp0_q [2];
    exe_pkg::exe_result_t exp1_q [2];
    logic                 br_exp_valid;
    logic                 br_exp_taken;
    logic                 br_exp_flush;
    logic [31:0]          br_exp_pc;
    logic [31:0]          br_exp_redirect;
    logic                 discard_next;
    logic                 mul_prev;
    logic [4:0]           mul_rd_prev;
    int                   errors;
    int                   cycles;
    string                phase_name [NUM_PHASES];
    int                   phase_len [NUM_PHASES];

    exe_top dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(
        input exe_pkg::alu_op_e op,
        input logic [31:0]      a,
        input logic [31:0]      b
    );
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exe_pkg::ALU_ADD:  return a + b;
            exe_pkg::ALU_SUB:  return a + ~b + 32'd1;
            exe_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            exe_pkg::ALU_SLTU: return {31'b0, a < b};
            exe_pkg::ALU_AND:  return a & b;
            exe_pkg::ALU_OR:   return a | b;
            exe_pkg::ALU_XOR:  return a ^ b;
            exe_pkg::ALU_NOR:  return ~a & ~b;
            exe_pkg::ALU_SLL:  return a << b[4:0];
            exe_pkg::ALU_SRL:  return a >> b[4:0];
            exe_pkg::ALU_SRA:  return ext[31:0];
            exe_pkg::ALU_LUI:  return b;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(
        input logic        sign,
        input logic        high,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = sign ? {{32{a[31]}}, a} : {32'b0, a};
        eb = sign ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ea * eb;
        return high ? p[63:32] : p[31:0];
    endfunction

    function automatic logic taken_ref(
        input exe_pkg::br_cond_e c,
        input logic [31:0]       a,
        input logic [31:0]       b
    );
        case (c)
            exe_pkg::BR_BEQ:  return a == b;
            exe_pkg::BR_BNE:  return a != b;
            exe_pkg::BR_BLT:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            exe_pkg::BR_BGE:  return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
            exe_pkg::BR_BLTU: return a < b;
            exe_pkg::BR_BGEU: return a >= b;
            default:          return 1'b1;
        endcase
    endfunction

    task automatic fail_stop(input string msg);
        errors++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic compare_result(
        input string                test,
        input string                what,
        input exe_pkg::exe_result_t exp,
        input exe_pkg::exe_result_t act
    );
        if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
            fail_stop($sformatf("MISMATCH %s %s expected %h actual %h", test, what, exp, act));
        end
    endtask

    task automatic compare_redirect(
        input string       test,
        input string       what,
        input logic [31:0] exp_pc,
        input logic        exp_bit,
        input logic [31:0] act_pc,
        input logic        act_bit
    );
        if (act_pc !== exp_pc || act_bit !== exp_bit) begin
            fail_stop($sformatf("MISMATCH %s %s expected %h/%b actual %h/%b",
                                test, what, exp_pc, exp_bit, act_pc, act_bit));
        end
    endtask

    task automatic compare_flag(
        input string test,
        input string what,
        input logic  exp,
        input logic  act
    );
        if (act !== exp) begin
            fail_stop($sformatf("MISMATCH %s %s expected %b actual %b", test, what, exp, act));
        end
    endtask

    // checks results of older bundles, then commits them
    task automatic check_outputs(input string test);
        exe_pkg::exe_result_t a0;
        exe_pkg::exe_result_t a1;
        if (dut0.props0.fail_count != 0) begin
            fail_stop("a concurrent assertion on the DUT outputs failed");
        end
        a0.valid = res0_valid;
        a0.rd    = res0_rd;
        a0.data  = res0_data;
        a1.valid = res1_valid;
        a1.rd    = res1_rd;
        a1.data  = res1_data;
        compare_result(test, "res0", exp0_q[1], a0);
        compare_result(test, "res1", exp1_q[1], a1);
        compare_flag(test, "branch_valid", br_exp_valid, branch_valid);
        compare_flag(test, "flush", br_exp_flush, flush);
        if (br_exp_valid) begin
            compare_redirect(test, "branch", br_exp_pc, br_exp_taken, branch_pc, branch_taken);
        end
        if (br_exp_flush) begin
            compare_redirect(test, "redirect", br_exp_redirect, 1'b1, redirect_pc, flush);
        end
        if (a0.valid && a0.rd != 0) begin
            comm_rf[a0.rd] = a0.data;
        end
        if (a1.valid && a1.rd != 0) begin
            comm_rf[a1.rd] = a1.data;
        end
        exp0_q[1] = exp0_q[0];
        exp1_q[1] = exp1_q[0];
    endtask

    function automatic logic [4:0] pick_src(input logic [4:0] mask, input logic [4:0] avoid,
                                            input logic use_avoid);
        logic [4:0] r;
        r = rand_bits(5) & mask;
        if (use_avoid && r == avoid) begin
            r = '0;
        end
        if (mul_prev && r == mul_rd_prev) begin
            r = '0;
        end
        return r;
    endfunction

    task automatic drive_bundle(input int mode, input int idx);
        exe_pkg::exe_uop_t    u0;
        exe_pkg::exe_uop_t    u1;
        exe_pkg::exe_result_t e0;
        exe_pkg::exe_result_t e1;
        logic                 discard;
        logic                 wbf;
        logic                 v0;
        logic                 v1;
        logic                 taken;
        logic                 is_bl;
        logic                 is_jirl;
        logic [4:0]           mask;
        logic [4:0]           rd0;
        logic [4:0]           rj0;
        logic [4:0]           rk0;
        logic [4:0]           rd1;
        logic [4:0]           rj1;
        logic [4:0]           rk1;
        logic [31:0]          imm0;
        logic [31:0]          imm1;
        logic [31:0]          pc;
        logic [31:0]          pc_next;
        logic [31:0]          tgt;
        logic [31:0]          cnext;
        logic [31:0]          r;
        int                   kind0;

        discard = discard_next;
        wbf     = (mode == P_WBF) && (idx % 7 == 6);
        v0      = (mode != P_IDLE) && !wbf && (rand_bits(3) != 0);
        v1      = (mode != P_IDLE) && !wbf && (rand_bits(3) != 0);
        mask    = (mode == P_FWD) ? 5'd3 : 5'd15;
        case (mode)
            P_MUL:   kind0 = rand_bits(1) ? 1 : 0;
            P_BR:    kind0 = rand_bits(1) ? 2 : 0;
            P_FLUSH: kind0 = 2;
            P_WBF:   kind0 = (rand_bits(2) == 0) ? 1 : 0;
            default: kind0 = 0;
        endcase

        u0   = '0;
        rd0  = rand_bits(5) & mask;
        rj0  = pick_src(mask, 5'd0, 1'b0);
        rk0  = pick_src(mask, 5'd0, 1'b0);
        imm0 = rand_bits(32);
        if (kind0 == 0) begin
            u0.is_alu   = 1'b1;
            u0.src2_imm = rand_bits(1);
            u0.op.alu   = exe_pkg::alu_op_e'(4'(rand_bits(4) % 12));
        end else if (kind0 == 1) begin
            u0.is_mul   = 1'b1;
            u0.mul_sign = rand_bits(1);
            u0.mul_high = rand_bits(1);
        end else begin
            u0.is_br = 1'b1;
            u0.op.br = exe_pkg::br_cond_e'(4'(rand_bits(4) % 9));
            imm0     = {{18{imm0[13]}}, imm0[13:2], 2'b00};
        end
        is_bl   = u0.is_br && u0.op.br == exe_pkg::BR_BL;
        is_jirl = u0.is_br && u0.op.br == exe_pkg::BR_JIRL;

        // lane 1 never reads what lane 0 of the same bundle writes
        u1        = '0;
        u1.is_alu = 1'b1;
        rd1       = rand_bits(5) & mask;
        rj1       = pick_src(mask, is_bl ? 5'd1 : rd0, !u0.is_br || is_bl || is_jirl);
        rk1       = pick_src(mask, is_bl ? 5'd1 : rd0, !u0.is_br || is_bl || is_jirl);
        imm1      = rand_bits(32);
        if (mode == P_MUL) begin
            u1.src2_imm = 1'b1;
            u1.op.alu   = exe_pkg::ALU_LUI;
            case (rand_bits(3))
                0:       imm1 = 32'h0000_0000;
                1:       imm1 = 32'h0000_0001;
                2:       imm1 = 32'h8000_0000;
                3:       imm1 = 32'hffff_ffff;
                4:       imm1 = 32'h7fff_ffff;
                default: imm1 = rand_bits(32);
            endcase
        end else begin
            u1.src2_imm = rand_bits(1);
            u1.op.alu   = exe_pkg::alu_op_e'(4'(rand_bits(4) % 12));
        end

        // expected results from the predicted register file
        r     = rand_bits(30);
        pc    = {r[29:0], 2'b00};
        taken = taken_ref(u0.op.br, pred_rf[rj0], pred_rf[rk0]);
        tgt   = is_jirl ? pred_rf[rj0] + imm0 : pc + imm0;
        cnext = taken ? tgt : pc + 32'd4;
        pc_next = rand_bits(1) ? cnext : cnext + 32'h10;

        e0.valid = v0 && !discard && (u0.is_alu || u0.is_mul || is_bl || is_jirl);
        e0.rd    = is_bl ? 5'd1 : rd0;
        if (u0.is_alu) begin
            e0.data = alu_ref(u0.op.alu, pred_rf[rj0], u0.src2_imm ? imm0 : pred_rf[rk0]);
        end else if (u0.is_mul) begin
            e0.data = mul_ref(u0.mul_sign, u0.mul_high, pred_rf[rj0], pred_rf[rk0]);
        end else begin
            e0.data = pc + 32'd4;
        end
        e1.valid = v1 && !discard;
        e1.rd    = rd1;
        e1.data  = alu_ref(u1.op.alu, pred_rf[rj1], u1.src2_imm ? imm1 : pred_rf[rk1]);

        br_exp_valid    = v0 && u0.is_br && !discard;
        br_exp_flush    = br_exp_valid && cnext != pc_next;
        br_exp_taken    = taken;
        br_exp_pc       = pc;
        br_exp_redirect = cnext;
        discard_next    = br_exp_flush;

        if (wbf) begin
            // in-flight bundle is cancelled, only committed state survives
            exp0_q[1] = '0;
            exp1_q[1] = '0;
            pred_rf   = comm_rf;
        end
        if (e0.valid && e0.rd != 0) begin
            pred_rf[e0.rd] = e0.data;
        end
        if (e1.valid && e1.rd != 0) begin
            pred_rf[e1.rd] = e1.data;
        end
        exp0_q[0]   = e0;
        exp1_q[0]   = e1;
        mul_prev    = v0 && u0.is_mul;
        mul_rd_prev = rd0;

        wb_flush      = wbf;
        lane0_valid   = v0;
        lane0_uop     = u0;
        lane0_rd      = rd0;
        lane0_rj      = rj0;
        lane0_rk      = rk0;
        lane0_imm     = imm0;
        lane0_pc      = pc;
        lane0_pc_next = pc_next;
        lane0_rj_data = comm_rf[rj0];
        lane0_rk_data = comm_rf[rk0];
        lane1_valid   = v1;
        lane1_uop     = u1;
        lane1_rd      = rd1;
        lane1_rj      = rj1;
        lane1_rk      = rk1;
        lane1_imm     = imm1;
        lane1_rj_data = comm_rf[rj1];
        lane1_rk_data = comm_rf[rk1];
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        wb_flush      = 1'b0;
        lane0_valid   = 1'b0;
        lane0_uop     = '0;
        lane0_rd      = '0;
        lane0_rj      = '0;
        lane0_rk      = '0;
        lane0_imm     = '0;
        lane0_pc      = '0;
        lane0_pc_next = '0;
        lane0_rj_data = '0;
        lane0_rk_data = '0;
        lane1_valid   = 1'b0;
        lane1_uop     = '0;
        lane1_rd      = '0;
        lane1_rj      = '0;
        lane1_rk      = '0;
        lane1_imm     = '0;
        lane1_rj_data = '0;
        lane1_rk_data = '0;
        lfsr          = 32'h0caf_5386;
        errors        = 0;
        cycles        = 0;
        exp0_q        = '{default: '0};
        exp1_q        = '{default: '0};
        br_exp_valid  = 1'b0;
        br_exp_flush  = 1'b0;
        discard_next  = 1'b0;
        mul_prev      = 1'b0;
        for (int k = 0; k < 32; k++) begin
            pred_rf[k] = '0;
            comm_rf[k] = '0;
        end
        phase_name = '{"alu", "forward", "mul", "branch", "flush", "wb_flush", "drain"};
        phase_len  = '{200, 200, 200, 200, 100, 150, 4};

        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int i = 0; i < phase_len[p]; i++) begin
                @(posedge clk);
                #1;
                check_outputs(phase_name[p]);
                #1;
                drive_bundle(p, i);
            end
        end

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hw/exe_alu.sv
`include "exe_defines.svh"

module exe_alu (
    input  exe_pkg::exe_uop_t    uop,
    input  logic [`EXE_XLEN-1:0] src_a,
    input  logic [`EXE_XLEN-1:0] src_b,
    input  logic [`EXE_XLEN-1:0] imm,
    output logic [`EXE_XLEN-1:0] result
);

    logic [`EXE_XLEN-1:0] opb;
    logic [4:0]           shamt;

    assign opb   = uop.src2_imm ? imm : src_b;
    assign shamt = opb[4:0];

    always_comb begin
        case (uop.op.alu)
            exe_pkg::ALU_ADD:  result = src_a + opb;
            exe_pkg::ALU_SUB:  result = src_a - opb;
            exe_pkg::ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, $signed(src_a) < $signed(opb)};
            exe_pkg::ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, src_a < opb};
            exe_pkg::ALU_AND:  result = src_a & opb;
            exe_pkg::ALU_OR:   result = src_a | opb;
            exe_pkg::ALU_XOR:  result = src_a ^ opb;
            exe_pkg::ALU_NOR:  result = ~(src_a | opb);
            exe_pkg::ALU_SLL:  result = src_a << shamt;
            exe_pkg::ALU_SRL:  result = src_a >> shamt;
            exe_pkg::ALU_SRA:  result = $unsigned($signed(src_a) >>> shamt);
            // immediate arrives already shifted
            exe_pkg::ALU_LUI:  result = opb;
            default:           result = '0;
        endcase
    end

endmodule

//--- hw/exe_branch.sv
`include "exe_defines.svh"

module exe_branch (
    input  exe_pkg::exe_uop_t    uop,
    input  logic [`EXE_XLEN-1:0] pc,
    input  logic [`EXE_XLEN-1:0] pc_next,
    input  logic [`EXE_XLEN-1:0] src_a,
    input  logic [`EXE_XLEN-1:0] src_b,
    input  logic [`EXE_XLEN-1:0] imm,
    output logic                 taken,
    output logic [`EXE_XLEN-1:0] target,
    output logic [`EXE_XLEN-1:0] correct_next,
    output logic                 mispredict,
    output logic [`EXE_XLEN-1:0] link_data
);

    always_comb begin
        case (uop.op.br)
            exe_pkg::BR_JIRL,
            exe_pkg::BR_B,
            exe_pkg::BR_BL:   taken = 1'b1;
            exe_pkg::BR_BEQ:  taken = src_a == src_b;
            exe_pkg::BR_BNE:  taken = src_a != src_b;
            exe_pkg::BR_BLT:  taken = $signed(src_a) < $signed(src_b);
            exe_pkg::BR_BGE:  taken = $signed(src_a) >= $signed(src_b);
            exe_pkg::BR_BLTU: taken = src_a < src_b;
            exe_pkg::BR_BGEU: taken = src_a >= src_b;
            default:          taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = (uop.op.br == exe_pkg::BR_JIRL) ? src_a + imm : pc + imm;

    assign link_data    = pc + `EXE_INST_BYTES;
    assign correct_next = taken ? target : link_data;
    assign mispredict   = correct_next != pc_next;

endmodule

//--- hw/exe_bypass_if.sv
interface exe_bypass_if;

    // middle stage, ALU and link results only
    exe_pkg::exe_result_t mid0;
    exe_pkg::exe_result_t mid1;

    // final stage, everything that writes back
    exe_pkg::exe_result_t fin0;
    exe_pkg::exe_result_t fin1;

    modport src (
        output mid0,
        output mid1,
        output fin0,
        output fin1
    );

    modport sink (
        input mid0,
        input mid1,
        input fin0,
        input fin1
    );

endinterface

//--- hw/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// data and address width
`define EXE_XLEN 32

// register file address width
`define EXE_REG_AW 5

// BL always writes r1
`define EXE_LINK_REG 5'd1

// step from pc to the sequential next pc
`define EXE_INST_BYTES 32'd4

`endif

//--- hw/exe_forward.sv
`include "exe_defines.svh"

module exe_forward (
    input  logic [`EXE_REG_AW-1:0] rj0,
    input  logic [`EXE_REG_AW-1:0] rk0,
    input  logic [`EXE_REG_AW-1:0] rj1,
    input  logic [`EXE_REG_AW-1:0] rk1,
    input  logic [`EXE_XLEN-1:0]   rj0_data,
    input  logic [`EXE_XLEN-1:0]   rk0_data,
    input  logic [`EXE_XLEN-1:0]   rj1_data,
    input  logic [`EXE_XLEN-1:0]   rk1_data,
    exe_bypass_if.sink             bp,
    output logic [`EXE_XLEN-1:0]   src0_a,
    output logic [`EXE_XLEN-1:0]   src0_b,
    output logic [`EXE_XLEN-1:0]   src1_a,
    output logic [`EXE_XLEN-1:0]   src1_b
);

    // youngest match wins, lane 1 before lane 0 within a stage
    function automatic logic [`EXE_XLEN-1:0] pick(
        input logic [`EXE_REG_AW-1:0] addr,
        input logic [`EXE_XLEN-1:0]   rf_data
    );
        if (addr == '0) begin
            return '0;
        end
        if (bp.mid1.valid && bp.mid1.rd == addr) begin
            return bp.mid1.data;
        end
        if (bp.mid0.valid && bp.mid0.rd == addr) begin
            return bp.mid0.data;
        end
        if (bp.fin1.valid && bp.fin1.rd == addr) begin
            return bp.fin1.data;
        end
        if (bp.fin0.valid && bp.fin0.rd == addr) begin
            return bp.fin0.data;
        end
        return rf_data;
    endfunction

    always_comb begin
        src0_a = pick(rj0, rj0_data);
        src0_b = pick(rk0, rk0_data);
        src1_a = pick(rj1, rj1_data);
        src1_b = pick(rk1, rk1_data);
    end

endmodule

//--- hw/exe_mul.sv
`include "exe_defines.svh"

module exe_mul (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clear,
    input  logic                   start,
    input  logic                   sign,
    input  logic                   high,
    input  logic [`EXE_XLEN-1:0]   src_a,
    input  logic [`EXE_XLEN-1:0]   src_b,
    input  logic [`EXE_REG_AW-1:0] rd,
    output exe_pkg::exe_result_t   res
);

    localparam int HW = `EXE_XLEN / 2;

    logic                     valid_q;
    logic                     high_q;
    logic [`EXE_REG_AW-1:0]   rd_q;
    logic [`EXE_XLEN-1:0]     ll_q;
    logic [`EXE_XLEN-1:0]     lh_q;
    logic [`EXE_XLEN-1:0]     hl_q;
    logic [`EXE_XLEN-1:0]     hh_q;
    logic [`EXE_XLEN-1:0]     corr_q;
    logic [2*`EXE_XLEN-1:0]   prod;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    // unsigned partial products, signed case fixed by the upper-word term
    always_ff @(posedge clk) begin
        if (start) begin
            high_q <= high;
            rd_q   <= rd;
            ll_q   <= src_a[HW-1:0] * src_b[HW-1:0];
            lh_q   <= src_a[HW-1:0] * src_b[`EXE_XLEN-1:HW];
            hl_q   <= src_a[`EXE_XLEN-1:HW] * src_b[HW-1:0];
            hh_q   <= src_a[`EXE_XLEN-1:HW] * src_b[`EXE_XLEN-1:HW];
            corr_q <= ((sign && src_a[`EXE_XLEN-1]) ? src_b : '0)
                    + ((sign && src_b[`EXE_XLEN-1]) ? src_a : '0);
        end
    end

    assign prod = {hh_q, ll_q}
                + {{HW{1'b0}}, lh_q, {HW{1'b0}}}
                + {{HW{1'b0}}, hl_q, {HW{1'b0}}}
                - {corr_q, {`EXE_XLEN{1'b0}}};

    assign res.valid = valid_q;
    assign res.rd    = rd_q;
    assign res.data  = high_q ? prod[2*`EXE_XLEN-1:`EXE_XLEN] : prod[`EXE_XLEN-1:0];

endmodule

//--- hw/exe_pkg.sv
`include "exe_defines.svh"

package exe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_JIRL,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_cond_e;

    // one op field, read by unit type
    typedef union packed {
        alu_op_e  alu;
        br_cond_e br;
    } uop_op_u;

    typedef struct packed {
        logic    is_alu;
        logic    is_mul;
        logic    is_br;
        logic    src2_imm;
        logic    mul_sign;
        logic    mul_high;
        uop_op_u op;
    } exe_uop_t;

    // one lane's writeback at one stage
    typedef struct packed {
        logic                   valid;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_XLEN-1:0]   data;
    } exe_result_t;

endpackage

//--- hw/exe_stage_regs.sv
`include "exe_defines.svh"

module exe_stage_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wb_flush,
    input  logic                   lane0_valid,
    input  exe_pkg::exe_uop_t      lane0_uop,
    input  logic [`EXE_REG_AW-1:0] lane0_rd,
    input  logic                   lane1_valid,
    input  exe_pkg::exe_uop_t      lane1_uop,
    input  logic [`EXE_REG_AW-1:0] lane1_rd,
    input  logic [`EXE_XLEN-1:0]   alu0_result,
    input  logic [`EXE_XLEN-1:0]   alu1_result,
    input  logic                   br_taken,
    input  logic [`EXE_XLEN-1:0]   br_target,
    input  logic [`EXE_XLEN-1:0]   br_correct_next,
    input  logic                   br_mispredict,
    input  logic [`EXE_XLEN-1:0]   br_link_data,
    input  logic [`EXE_XLEN-1:0]   lane0_pc,
    input  exe_pkg::exe_result_t   mul_res,
    output logic                   mul_start,
    output logic                   mul_clear,
    output logic                   flush,
    output logic [`EXE_XLEN-1:0]   redirect_pc,
    output logic                   branch_valid,
    output logic                   branch_taken,
    output logic [`EXE_XLEN-1:0]   branch_pc,
    output exe_pkg::exe_result_t   res0,
    output exe_pkg::exe_result_t   res1,
    exe_bypass_if.src              bp
);

    logic                 br_en;
    logic                 is_bl;
    logic                 link_en;
    exe_pkg::exe_result_t mid0_d;
    exe_pkg::exe_result_t mid1_d;
    exe_pkg::exe_result_t mid0_q;
    exe_pkg::exe_result_t mid1_q;

    assign br_en   = lane0_valid && lane0_uop.is_br;
    assign is_bl   = lane0_uop.op.br == exe_pkg::BR_BL;
    assign link_en = is_bl || lane0_uop.op.br == exe_pkg::BR_JIRL;

    // BL links to r1, JIRL to its own rd
    assign mid0_d.valid = lane0_valid && (lane0_uop.is_alu || (lane0_uop.is_br && link_en));
    assign mid0_d.rd    = (lane0_uop.is_br && is_bl) ? `EXE_LINK_REG : lane0_rd;
    assign mid0_d.data  = lane0_uop.is_br ? br_link_data : alu0_result;

    assign mid1_d.valid = lane1_valid && lane1_uop.is_alu;
    assign mid1_d.rd    = lane1_rd;
    assign mid1_d.data  = alu1_result;

    assign mul_start = lane0_valid && lane0_uop.is_mul && !flush;
    assign mul_clear = flush || wb_flush;

    // middle stage, a bundle arriving under flush is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid0_q       <= '0;
            mid1_q       <= '0;
            branch_valid <= 1'b0;
            flush        <= 1'b0;
        end else if (mul_clear) begin
            mid0_q       <= '0;
            mid1_q       <= '0;
            branch_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            mid0_q       <= mid0_d;
            mid1_q       <= mid1_d;
            branch_valid <= br_en;
            flush        <= br_en && br_mispredict;
        end
    end

    // target goes to the predictor unless a redirect is due
    always_ff @(posedge clk) begin
        branch_taken <= br_taken;
        branch_pc    <= lane0_pc;
        redirect_pc  <= br_mispredict ? br_correct_next : br_target;
    end

    // final stage, mid0 and the multiplier never both valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res0 <= '0;
            res1 <= '0;
        end else if (wb_flush) begin
            res0 <= '0;
            res1 <= '0;
        end else begin
            res0 <= mid0_q.valid ? mid0_q : mul_res;
            res1 <= mid1_q;
        end
    end

    assign bp.mid0 = mid0_q;
    assign bp.mid1 = mid1_q;
    assign bp.fin0 = res0;
    assign bp.fin1 = res1;

endmodule

//--- hw/exe_top.sv
`include "exe_defines.svh"

module exe_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wb_flush,
    input  logic                   lane0_valid,
    input  exe_pkg::exe_uop_t      lane0_uop,
    input  logic [`EXE_REG_AW-1:0] lane0_rd,
    input  logic [`EXE_REG_AW-1:0] lane0_rj,
    input  logic [`EXE_REG_AW-1:0] lane0_rk,
    input  logic [`EXE_XLEN-1:0]   lane0_imm,
    input  logic [`EXE_XLEN-1:0]   lane0_pc,
    input  logic [`EXE_XLEN-1:0]   lane0_pc_next,
    input  logic [`EXE_XLEN-1:0]   lane0_rj_data,
    input  logic [`EXE_XLEN-1:0]   lane0_rk_data,
    input  logic                   lane1_valid,
    input  exe_pkg::exe_uop_t      lane1_uop,
    input  logic [`EXE_REG_AW-1:0] lane1_rd,
    input  logic [`EXE_REG_AW-1:0] lane1_rj,
    input  logic [`EXE_REG_AW-1:0] lane1_rk,
    input  logic [`EXE_XLEN-1:0]   lane1_imm,
    input  logic [`EXE_XLEN-1:0]   lane1_rj_data,
    input  logic [`EXE_XLEN-1:0]   lane1_rk_data,
    output logic                   res0_valid,
    output logic [`EXE_REG_AW-1:0] res0_rd,
    output logic [`EXE_XLEN-1:0]   res0_data,
    output logic                   res1_valid,
    output logic [`EXE_REG_AW-1:0] res1_rd,
    output logic [`EXE_XLEN-1:0]   res1_data,
    output logic                   flush,
    output logic [`EXE_XLEN-1:0]   redirect_pc,
    output logic                   branch_valid,
    output logic                   branch_taken,
    output logic [`EXE_XLEN-1:0]   branch_pc
);

    logic [`EXE_XLEN-1:0] src0_a;
    logic [`EXE_XLEN-1:0] src0_b;
    logic [`EXE_XLEN-1:0] src1_a;
    logic [`EXE_XLEN-1:0] src1_b;
    logic [`EXE_XLEN-1:0] alu0_result;
    logic [`EXE_XLEN-1:0] alu1_result;
    logic                 br_taken;
    logic [`EXE_XLEN-1:0] br_target;
    logic [`EXE_XLEN-1:0] br_correct_next;
    logic                 br_mispredict;
    logic [`EXE_XLEN-1:0] br_link_data;
    logic                 mul_start;
    logic                 mul_clear;
    exe_pkg::exe_result_t mul_res;
    exe_pkg::exe_result_t res0;
    exe_pkg::exe_result_t res1;

    exe_bypass_if bp ();

    exe_forward forward (
        .rj0      (lane0_rj),
        .rk0      (lane0_rk),
        .rj1      (lane1_rj),
        .rk1      (lane1_rk),
        .rj0_data (lane0_rj_data),
        .rk0_data (lane0_rk_data),
        .rj1_data (lane1_rj_data),
        .rk1_data (lane1_rk_data),
        .bp       (bp.sink),
        .src0_a   (src0_a),
        .src0_b   (src0_b),
        .src1_a   (src1_a),
        .src1_b   (src1_b)
    );

    exe_alu alu0 (
        .uop    (lane0_uop),
        .src_a  (src0_a),
        .src_b  (src0_b),
        .imm    (lane0_imm),
        .result (alu0_result)
    );

    exe_alu alu1 (
        .uop    (lane1_uop),
        .src_a  (src1_a),
        .src_b  (src1_b),
        .imm    (lane1_imm),
        .result (alu1_result)
    );

    exe_branch branch (
        .uop          (lane0_uop),
        .pc           (lane0_pc),
        .pc_next      (lane0_pc_next),
        .src_a        (src0_a),
        .src_b        (src0_b),
        .imm          (lane0_imm),
        .taken        (br_taken),
        .target       (br_target),
        .correct_next (br_correct_next),
        .mispredict   (br_mispredict),
        .link_data    (br_link_data)
    );

    exe_mul mul (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (mul_clear),
        .start  (mul_start),
        .sign   (lane0_uop.mul_sign),
        .high   (lane0_uop.mul_high),
        .src_a  (src0_a),
        .src_b  (src0_b),
        .rd     (lane0_rd),
        .res    (mul_res)
    );

    exe_stage_regs stage_regs (
        .clk             (clk),
        .arst_n          (arst_n),
        .wb_flush        (wb_flush),
        .lane0_valid     (lane0_valid),
        .lane0_uop       (lane0_uop),
        .lane0_rd        (lane0_rd),
        .lane1_valid     (lane1_valid),
        .lane1_uop       (lane1_uop),
        .lane1_rd        (lane1_rd),
        .alu0_result     (alu0_result),
        .alu1_result     (alu1_result),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .br_correct_next (br_correct_next),
        .br_mispredict   (br_mispredict),
        .br_link_data    (br_link_data),
        .lane0_pc        (lane0_pc),
        .mul_res         (mul_res),
        .mul_start       (mul_start),
        .mul_clear       (mul_clear),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .branch_valid    (branch_valid),
        .branch_taken    (branch_taken),
        .branch_pc       (branch_pc),
        .res0            (res0),
        .res1            (res1),
        .bp              (bp.src)
    );

    assign res0_valid = res0.valid;
    assign res0_rd    = res0.rd;
    assign res0_data  = res0.data;
    assign res1_valid = res1.valid;
    assign res1_rd    = res1.rd;
    assign res1_data  = res1.data;

endmodule

//--- sim.f
+incdir+hw
hw/exe_pkg.sv
hw/exe_bypass_if.sv
hw/exe_forward.sv
hw/exe_alu.sv
hw/exe_branch.sv
hw/exe_mul.sv
hw/exe_stage_regs.sv
hw/exe_top.sv
bench/exe_props.sv
bench/exe_tb.sv
